// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
design/rv_core_pkg.sv
design/imm_gen.sv
design/control_decode.sv
design/pc_unit.sv
design/reg_file.sv
design/load_store_unit.sv
design/data_mem.sv
design/rv_core_top.sv
verification/tb_clock_gen.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

// File: design/control_decode.sv
module control_decode (
  input  rv_core_pkg::inst_u inst,
  output rv_core_pkg::ctrl_t ctrl
);
  import rv_core_pkg::*;

  always_comb begin
    // unknown opcode: no writes, just step the pc
    ctrl.reg_we    = 1'b0;
    ctrl.mem_re    = 1'b0;
    ctrl.mem_we    = 1'b0;
    ctrl.is_ebreak = 1'b0;
    ctrl.opa_sel   = opa_rs1;
    ctrl.imm_sel   = imm_i;
    ctrl.wb_sel    = wb_alu;
    ctrl.pc_sel    = pc_seq;

    case (inst.r_view.opcode)
      op_imm: begin // whole group handled as addi
        ctrl.reg_we = 1'b1;
      end
      op_lui: begin
        ctrl.reg_we  = 1'b1;
        ctrl.opa_sel = opa_zero; // 0 + (imm20 << 12)
        ctrl.imm_sel = imm_u;
      end
      op_auipc: begin
        ctrl.reg_we  = 1'b1;
        ctrl.opa_sel = opa_pc;
        ctrl.imm_sel = imm_u;
      end
      op_jal: begin
        ctrl.reg_we  = 1'b1;
        ctrl.opa_sel = opa_pc;
        ctrl.imm_sel = imm_j;
        ctrl.wb_sel  = wb_link;
        ctrl.pc_sel  = pc_target;
      end
      op_jalr: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = wb_link;
        ctrl.pc_sel = pc_target;
      end
      op_load: begin
        ctrl.reg_we = 1'b1;
        ctrl.mem_re = 1'b1;
        ctrl.wb_sel = wb_load;
      end
      op_store: begin
        ctrl.mem_we  = 1'b1;
        ctrl.imm_sel = imm_s;
      end
      op_system: begin
        ctrl.is_ebreak = 1'b1; // only ebreak is expected here
      end
      default: begin
      end
    endcase
  end

endmodule

// File: design/data_mem.sv
module data_mem (
  input  logic                          clk,
  input  rv_core_pkg::mem_req_t         req,
  input  logic                          we,
  output logic [rv_core_pkg::xlen-1:0]  rdata
);
  import rv_core_pkg::*;

  logic [xlen-1:0]           mem [2**dmem_addr_bits];
  logic [dmem_addr_bits-1:0] idx;

  // upper address bits are ignored, so the array repeats
  assign idx = req.addr[dmem_addr_bits+1:2];

  always_ff @(posedge clk) begin
    if (we && (req.mask != 4'b0000)) begin
      for (int b = 0; b < 4; b++) begin
        if (req.mask[b]) begin
          mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  assign rdata = mem[idx]; // async read, sees stores from earlier edges

endmodule

// File: design/imm_gen.sv
module imm_gen (
  input  rv_core_pkg::inst_u              inst,
  input  rv_core_pkg::imm_sel_e           imm_sel,
  output logic [rv_core_pkg::xlen-1:0]    imm
);
  import rv_core_pkg::*;

  logic [xlen-1:0] imm_i_ext;
  logic [xlen-1:0] imm_s_ext;
  logic [xlen-1:0] imm_u_ext;
  logic [xlen-1:0] imm_j_ext;
  logic            sign;

  assign sign = inst.u_view.imm20[19]; // inst[31] for every format

  assign imm_i_ext = {{20{sign}}, inst.i_view.imm12};
  assign imm_s_ext = {{20{sign}}, inst.s_view.imm_hi, inst.s_view.imm_lo};
  assign imm_u_ext = {inst.u_view.imm20, 12'h000};

  // j layout is imm[20|10:1|11|19:12] in inst[31:12]
  assign imm_j_ext = {{11{sign}},
                      sign,
                      inst.u_view.imm20[7:0],   // imm[19:12]
                      inst.u_view.imm20[8],     // imm[11]
                      inst.u_view.imm20[18:9],  // imm[10:1]
                      1'b0};

  always_comb begin
    case (imm_sel)
      imm_i:   imm = imm_i_ext;
      imm_s:   imm = imm_s_ext;
      imm_u:   imm = imm_u_ext;
      imm_j:   imm = imm_j_ext;
      default: imm = imm_i_ext;
    endcase
  end

endmodule

// File: design/load_store_unit.sv
module load_store_unit (
  input  logic [2:0]                    funct3,
  input  logic [rv_core_pkg::xlen-1:0]  addr,
  input  logic [rv_core_pkg::xlen-1:0]  store_data,
  input  logic                          mem_we,
  input  logic [rv_core_pkg::xlen-1:0]  rdata,
  output rv_core_pkg::mem_req_t         req,
  output logic [rv_core_pkg::xlen-1:0]  load_data
);
  import rv_core_pkg::*;

  logic [1:0]      offset;
  logic [3:0]      mask;
  logic [xlen-1:0] lanes;
  logic [xlen-1:0] shifted; // addressed byte moved down to bit 0

  assign offset = addr[1:0];

  // store side
  always_comb begin
    mask  = 4'b0000;
    lanes = store_data;
    case (funct3)
      f3_byte: begin
        mask  = 4'b0001 << offset;
        lanes = {4{store_data[7:0]}};
      end
      f3_half: begin
        if (!offset[0]) begin
          mask = 4'b0011 << offset;
        end
        lanes = {2{store_data[15:0]}};
      end
      f3_word: begin
        if (offset == 2'b00) begin
          mask = 4'b1111;
        end
      end
      default: mask = 4'b0000;
    endcase
    if (!mem_we) begin
      mask = 4'b0000;
    end
  end

  assign req.addr  = addr;
  assign req.wdata = lanes;
  assign req.mask  = mask;

  // load side
  assign shifted = rdata >> {offset, 3'b000};

  always_comb begin
    load_data = '0; // misaligned or unknown size
    case (funct3)
      f3_byte:   load_data = {{24{shifted[7]}}, shifted[7:0]};
      f3_byte_u: load_data = {24'h00_0000, shifted[7:0]};
      f3_half: begin
        if (!offset[0]) load_data = {{16{shifted[15]}}, shifted[15:0]};
      end
      f3_half_u: begin
        if (!offset[0]) load_data = {16'h0000, shifted[15:0]};
      end
      f3_word: begin
        if (offset == 2'b00) load_data = rdata;
      end
      default: load_data = '0;
    endcase
  end

endmodule

// File: design/pc_unit.sv
module pc_unit (
  input  logic                          clk,
  input  logic                          reset,
  input  rv_core_pkg::pc_sel_e          pc_sel,
  input  logic [rv_core_pkg::xlen-1:0]  target,
  input  logic                          is_ebreak,
  output logic [rv_core_pkg::xlen-1:0]  pc,
  output logic [rv_core_pkg::xlen-1:0]  pc_plus4,
  output logic                          halted
);
  import rv_core_pkg::*;

  logic [xlen-1:0] next_pc;

  assign pc_plus4 = pc + 32'd4;

  // jump targets always land on an even address
  assign next_pc = (pc_sel == pc_target) ? {target[xlen-1:1], 1'b0} : pc_plus4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= pc_reset;
      halted <= 1'b0;
    end else begin
      if (!halted) begin
        pc <= next_pc;
      end
      if (is_ebreak) begin
        halted <= 1'b1; // sticky until reset
      end
    end
  end

endmodule

// File: design/reg_file.sv
module reg_file (
  input  logic                                clk,
  input  logic                                we,
  input  logic [rv_core_pkg::reg_addr_w-1:0]  waddr,
  input  logic [rv_core_pkg::reg_addr_w-1:0]  raddr1,
  input  logic [rv_core_pkg::reg_addr_w-1:0]  raddr2,
  input  logic [rv_core_pkg::xlen-1:0]        wdata,
  output logic [rv_core_pkg::xlen-1:0]        rdata1,
  output logic [rv_core_pkg::xlen-1:0]        rdata2
);
  import rv_core_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads as zero whatever the array holds
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: design/rv_core_pkg.sv
package rv_core_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int dmem_addr_bits = 8; // 256 words
  localparam logic [xlen-1:0] pc_reset = 32'h8000_0000;

  // major opcodes of the supported subset
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_system = 7'b111_0011;

  // access size for loads and stores
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  typedef enum logic [1:0] {wb_alu, wb_link, wb_load} wb_sel_e;
  typedef enum logic {pc_seq, pc_target} pc_sel_e;
  typedef enum logic [1:0] {opa_rs1, opa_pc, opa_zero} opa_sel_e;
  typedef enum logic [1:0] {imm_i, imm_s, imm_u, imm_j} imm_sel_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]           imm20; // inst[31:12], also the raw j bits
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  // one instruction word, several decodings
  typedef union packed {
    r_fmt_t r_view;
    i_fmt_t i_view;
    s_fmt_t s_view;
    u_fmt_t u_view;
  } inst_u;

  typedef struct packed {
    logic     reg_we;
    logic     mem_re;
    logic     mem_we;
    logic     is_ebreak;
    opa_sel_e opa_sel;
    imm_sel_e imm_sel;
    wb_sel_e  wb_sel;
    pc_sel_e  pc_sel;
  } ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] addr;  // byte address, memory uses the word bits
    logic [xlen-1:0] wdata; // already replicated into lanes
    logic [3:0]      mask;
  } mem_req_t;

  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } wb_t;

endpackage

// File: design/rv_core_top.sv
module rv_core_top (
  input  logic                          clk,
  input  logic                          reset,
  input  rv_core_pkg::inst_u            inst,
  output logic [rv_core_pkg::xlen-1:0]  pc,
  output logic                          halted,
  output rv_core_pkg::wb_t              wb
);
  import rv_core_pkg::*;

  ctrl_t           ctrl;
  mem_req_t        mem_req;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] opa;
  logic [xlen-1:0] sum;       // alu result, jump target and mem address
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] mem_rdata;
  logic [xlen-1:0] lsu_rdata;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] rd_data;
  logic            reg_wr;
  logic            mem_wr;

  control_decode u_decode (.inst(inst), .ctrl(ctrl));

  imm_gen u_imm (.inst(inst), .imm_sel(ctrl.imm_sel), .imm(imm));

  pc_unit u_pc (
    .clk      (clk),
    .reset    (reset),
    .pc_sel   (ctrl.pc_sel),
    .target   (sum),
    .is_ebreak(ctrl.is_ebreak),
    .pc       (pc),
    .pc_plus4 (pc_plus4),
    .halted   (halted)
  );

  // nothing architectural changes once halted
  assign reg_wr = ctrl.reg_we & ~halted;
  assign mem_wr = ctrl.mem_we & ~halted;

  reg_file u_rf (
    .clk   (clk),
    .we    (reg_wr),
    .waddr (inst.r_view.rd),
    .raddr1(inst.r_view.rs1),
    .raddr2(inst.r_view.rs2),
    .wdata (rd_data),
    .rdata1(rs1_data),
    .rdata2(rs2_data)
  );

  always_comb begin
    case (ctrl.opa_sel)
      opa_pc:   opa = pc;
      opa_zero: opa = '0;
      default:  opa = rs1_data;
    endcase
  end

  assign sum = opa + imm;

  assign lsu_rdata = ctrl.mem_re ? mem_rdata : '0;

  load_store_unit u_lsu (
    .funct3    (inst.r_view.funct3),
    .addr      (sum),
    .store_data(rs2_data),
    .mem_we    (mem_wr),
    .rdata     (lsu_rdata),
    .req       (mem_req),
    .load_data (load_data)
  );

  data_mem u_dmem (.clk(clk), .req(mem_req), .we(mem_wr), .rdata(mem_rdata));

  always_comb begin
    case (ctrl.wb_sel)
      wb_link: rd_data = pc_plus4;
      wb_load: rd_data = load_data;
      default: rd_data = sum;
    endcase
  end

  // trace shows only writes that land in a real register
  assign wb.valid = reg_wr & (inst.r_view.rd != '0);
  assign wb.rd    = inst.r_view.rd;
  assign wb.data  = rd_data;

endmodule

// File: verification/rv_core_checker.sv
module rv_core_checker (
  input logic                          clk,
  input logic                          reset,
  input logic [rv_core_pkg::xlen-1:0]  pc,
  input logic                          halted,
  input rv_core_pkg::wb_t              wb
);

  int fail_count; // read by the testbench at the end

  initial fail_count = 0;

  // halt is sticky until the next reset
  a_halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else begin
      fail_count++;
      $error("halted dropped while reset was low");
    end

  a_pc_hold: assert property (@(posedge clk) disable iff (reset) halted |=> $stable(pc))
    else begin
      fail_count++;
      $error("pc moved while the core was halted");
    end

  // trace never reports a write to x0
  a_wb_rd: assert property (@(posedge clk) disable iff (reset) wb.valid |-> (wb.rd != '0))
    else begin
      fail_count++;
      $error("writeback trace valid with rd equal to zero");
    end

endmodule

bind rv_core_top rv_core_checker chk (
  .clk   (clk),
  .reset (reset),
  .pc    (pc),
  .halted(halted),
  .wb    (wb)
);

// File: verification/rv_core_tb.sv
module rv_core_tb;
  import rv_core_pkg::*;

  typedef struct packed {
    logic [xlen-1:0] word;
    logic [xlen-1:0] pc;     // pc while the word is presented
    wb_t             wb;
    logic            halted;
  } step_t;

  logic            clk;
  logic            reset;
  inst_u           inst;
  logic [xlen-1:0] pc;
  logic            halted;
  wb_t             wb;

  step_t           steps[$];
  logic [xlen-1:0] model_pc;
  logic            model_halt;
  int              errors = 0;

  tb_clock_gen u_clk (.clk(clk));

  rv_core_top uut (.clk(clk), .reset(reset), .inst(inst), .pc(pc), .halted(halted), .wb(wb));

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  // imm is the byte offset, bit 0 dropped by the format
  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  task automatic add_step(input logic [31:0] word, input logic wr, input logic [4:0] rd,
                          input logic [31:0] data, input logic [31:0] next_pc,
                          input logic stops);
    step_t s;
    s.word     = word;
    s.pc       = model_pc;
    s.halted   = model_halt;
    s.wb.valid = wr && (rd != 5'd0) && !model_halt;
    s.wb.rd    = rd;
    s.wb.data  = data;
    steps.push_back(s);
    if (!model_halt) model_pc = next_pc; // the ebreak edge itself still steps
    if (stops) model_halt = 1'b1;
  endtask

  task automatic add_seq(input logic [31:0] word, input logic wr, input logic [4:0] rd,
                         input logic [31:0] data);
    add_step(word, wr, rd, data, model_pc + 32'd4, 1'b0);
  endtask

  // lui then addi, upper part rounded for the signed low half
  task automatic add_li(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] rounded;
    rounded = value + 32'h0000_0800;
    add_seq(enc_u(rounded[31:12], rd, op_lui), 1'b1, rd, {rounded[31:12], 12'h000});
    add_seq(enc_i(value[11:0], rd, 3'b000, rd, op_imm), 1'b1, rd, value);
  endtask

  task automatic build_table();
    logic [31:0] d1;
    logic [31:0] d2;
    logic [31:0] link;
    model_pc   = pc_reset;
    model_halt = 1'b0;
    d1 = $urandom;
    d2 = $urandom;
    d2[15] = 1'b1; // lh and lhu must differ
    add_seq(enc_i(12'h000, 5'd0, 3'b000, 5'd0, op_imm), 1'b1, 5'd0, 32'h0); // nop
    add_seq(enc_i(12'h100, 5'd0, 3'b000, 5'd1, op_imm), 1'b1, 5'd1, 32'h0000_0100);
    add_seq(enc_i(12'hffc, 5'd1, 3'b000, 5'd2, op_imm), 1'b1, 5'd2, 32'h0000_00fc);
    add_seq(enc_u(20'h12345, 5'd3, op_lui), 1'b1, 5'd3, 32'h1234_5000);
    add_seq(enc_u(20'h00001, 5'd4, op_auipc), 1'b1, 5'd4, model_pc + 32'h0000_1000);
    add_seq(enc_i(12'h005, 5'd1, 3'b000, 5'd0, op_imm), 1'b1, 5'd0, 32'h0); // x0 target
    add_seq(enc_i(12'h007, 5'd0, 3'b000, 5'd5, op_imm), 1'b1, 5'd5, 32'h0000_0007);
    add_seq({7'b0, 5'd2, 5'd1, 3'b000, 5'd6, 7'b011_0011}, 1'b0, 5'd6, 32'h0); // r-type
    add_li(5'd6, d1);
    add_li(5'd7, d2);
    add_seq(enc_s(12'h000, 5'd6, 5'd1, f3_word), 1'b0, 5'd0, 32'h0);
    add_seq(enc_s(12'h008, 5'd6, 5'd1, f3_word), 1'b0, 5'd0, 32'h0);
    add_seq(enc_s(12'h004, 5'd7, 5'd1, f3_half), 1'b0, 5'd0, 32'h0);
    add_seq(enc_s(12'h006, 5'd7, 5'd1, f3_half), 1'b0, 5'd0, 32'h0);
    add_seq(enc_s(12'h009, 5'd7, 5'd1, f3_byte), 1'b0, 5'd0, 32'h0);
    add_seq(enc_s(12'h002, 5'd7, 5'd1, f3_word), 1'b0, 5'd0, 32'h0); // misaligned sw
    add_seq(enc_i(12'h000, 5'd1, f3_word, 5'd8, op_load), 1'b1, 5'd8, d1);
    add_seq(enc_i(12'h006, 5'd1, f3_half, 5'd9, op_load), 1'b1, 5'd9,
            {{16{d2[15]}}, d2[15:0]});
    add_seq(enc_i(12'h004, 5'd1, f3_half_u, 5'd10, op_load), 1'b1, 5'd10,
            {16'h0000, d2[15:0]});
    add_seq(enc_i(12'h009, 5'd1, f3_byte, 5'd11, op_load), 1'b1, 5'd11,
            {{24{d2[7]}}, d2[7:0]});
    add_seq(enc_i(12'h008, 5'd1, f3_byte_u, 5'd12, op_load), 1'b1, 5'd12,
            {24'h00_0000, d1[7:0]});
    add_seq(enc_i(12'h008, 5'd1, f3_word, 5'd13, op_load), 1'b1, 5'd13,
            {d1[31:16], d2[7:0], d1[7:0]});
    add_seq(enc_i(12'h001, 5'd1, f3_half, 5'd14, op_load), 1'b1, 5'd14, 32'h0); // misaligned
    add_seq(enc_i(12'h003, 5'd1, f3_byte, 5'd15, op_load), 1'b1, 5'd15,
            {{24{d1[31]}}, d1[31:24]});
    add_step(enc_j(21'd12, 5'd16), 1'b1, 5'd16, model_pc + 32'd4, model_pc + 32'd12, 1'b0);
    link = model_pc + 32'd4;
    // 0x100 + 0x21, bit 0 cleared
    add_step(enc_i(12'h021, 5'd1, 3'b000, 5'd17, op_jalr), 1'b1, 5'd17, link,
             32'h0000_0120, 1'b0);
    add_seq(enc_i(12'h000, 5'd17, 3'b000, 5'd18, op_imm), 1'b1, 5'd18, link);
    add_seq(enc_u(20'h00000, 5'd19, op_auipc), 1'b1, 5'd19, 32'h0000_0124);
    add_step(enc_j(21'h1f_fff8, 5'd20), 1'b1, 5'd20, model_pc + 32'd4, model_pc - 32'd8, 1'b0);
    add_step(32'h0010_0073, 1'b0, 5'd0, 32'h0, model_pc + 32'd4, 1'b1); // ebreak
    add_seq(enc_i(12'h001, 5'd0, 3'b000, 5'd21, op_imm), 1'b1, 5'd21, 32'h1);
    add_seq(enc_j(21'd16, 5'd22), 1'b1, 5'd22, 32'h0);
    add_seq(enc_i(12'h000, 5'd1, f3_word, 5'd23, op_load), 1'b1, 5'd23, d1);
  endtask

  task automatic check_pc(input string name, input logic [xlen-1:0] exp,
                          input logic [xlen-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_wb(input wb_t exp, input wb_t act);
    if ((act.valid !== exp.valid) ||
        (exp.valid && ((act.rd !== exp.rd) || (act.data !== exp.data)))) begin
      errors++;
      $display("MISMATCH t=%0t wb expected %b/x%0d/%h actual %b/x%0d/%h", $time,
               exp.valid, exp.rd, exp.data, act.valid, act.rd, act.data);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // entry 0 is already on inst when reset drops
  task automatic run_steps();
    for (int i = 0; i < steps.size(); i++) begin
      if (i > 0) begin
        @(posedge clk);
        inst <= steps[i].word;
        @(negedge clk);
      end
      check_pc("pc", steps[i].pc, pc);
      check_wb(steps[i].wb, wb);
      check_flag("halted", steps[i].halted, halted);
    end
  endtask

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  end

  initial begin
    int wait_cycles;
    int assert_fails;
    void'($urandom(46));
    build_table();
    inst = steps[0].word;
    wait_cycles = 0;
    while ((reset !== 1'b0) && (wait_cycles < 64)) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (reset !== 1'b0) begin
      $display("reset still high after %0d cycles, giving up", wait_cycles);
      $display("TB FAILED");
      $finish;
    end else begin
      run_steps();
      assert_fails = uut.chk.fail_count;
      $display("errors: compare %0d, assertion %0d", errors, assert_fails);
      if ((errors == 0) && (assert_fails == 0)) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk
);

  initial clk = 1'b0;

  always #4 clk = ~clk; // period of 8

endmodule
